// ==== hdl/rv_pkg.sv ====
package rv_pkg;

  // data path widths
  localparam int XLEN      = 32;
  localparam int REG_COUNT = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     insn_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [6:0]      opcode_t;

  // major opcodes of the supported classes
  localparam opcode_t OPCODE_LUI    = 7'b0110111;
  localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
  localparam opcode_t OPCODE_OP     = 7'b0110011;
  localparam opcode_t OPCODE_BRANCH = 7'b1100011;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_SLL  = 3'b001;
  localparam logic [2:0] FUNCT3_SLT  = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU = 3'b011;
  localparam logic [2:0] FUNCT3_XOR  = 3'b100;
  localparam logic [2:0] FUNCT3_SR   = 3'b101;
  localparam logic [2:0] FUNCT3_OR   = 3'b110;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  // sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  localparam insn_t NOP_INSN = 32'h0000_0000;
  localparam word_t PC_STEP  = 32'd4;
  localparam word_t RESET_PC = 32'd0;

  // class of the cycle seen in writeback
  typedef enum logic [2:0] {
    CYCLE_INVALID      = 3'd0,
    CYCLE_RESET        = 3'd1,
    CYCLE_NO_STALL     = 3'd2,
    CYCLE_TAKEN_BRANCH = 3'd4
  } cycle_status_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_IMM
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_cond_e;

  // contents of the decode register
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
  } decode_stage_t;

  // contents of the execute register
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    reg_idx_t      rd;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    logic          rd_write;
    logic          use_imm;
    alu_op_e       alu_op;
    br_cond_e      br_cond;
    word_t         rs1_data;
    word_t         rs2_data;
    word_t         imm;
  } execute_stage_t;

  // memory and writeback registers
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    reg_idx_t      rd;
    logic          rd_write;
    word_t         result;
  } result_stage_t;

endpackage

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  logic             we,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:REG_COUNT-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // write-through gives the WD bypass
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1 != '0) begin
      rs1_data = (we && (rd == rs1)) ? rd_data : regs[rs1];
    end
    if (rs2 != '0) begin
      rs2_data = (we && (rd == rs2)) ? rd_data : regs[rs2];
    end
  end

endmodule

// ==== hdl/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  input  logic          branch_taken,
  input  rv_pkg::word_t branch_target,
  output rv_pkg::word_t pc
);
  import rv_pkg::*;

  word_t pc_next;

  // redirect wins over the sequential step
  always_comb begin
    if (branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc + PC_STEP;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== hdl/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::decode_stage_t  stage,
  output rv_pkg::reg_idx_t       rs1,
  output rv_pkg::reg_idx_t       rs2,
  input  rv_pkg::word_t          rs1_data,
  input  rv_pkg::word_t          rs2_data,
  output rv_pkg::execute_stage_t decoded
);
  import rv_pkg::*;

  opcode_t    opcode;
  reg_idx_t   rd;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;

  function automatic alu_op_e alu_from_funct3(logic [2:0] f3, logic sub_sel, logic sra_sel);
    case (f3)
      FUNCT3_ADD:  return sub_sel ? ALU_SUB : ALU_ADD;
      FUNCT3_SLL:  return ALU_SLL;
      FUNCT3_SLT:  return ALU_SLT;
      FUNCT3_SLTU: return ALU_SLTU;
      FUNCT3_XOR:  return ALU_XOR;
      FUNCT3_SR:   return sra_sel ? ALU_SRA : ALU_SRL;
      FUNCT3_OR:   return ALU_OR;
      FUNCT3_AND:  return ALU_AND;
      default:     return ALU_ADD;
    endcase
  endfunction

  function automatic br_cond_e branch_from_funct3(logic [2:0] f3);
    case (f3)
      FUNCT3_BEQ:  return BR_EQ;
      FUNCT3_BNE:  return BR_NE;
      FUNCT3_BLT:  return BR_LT;
      FUNCT3_BGE:  return BR_GE;
      FUNCT3_BLTU: return BR_LTU;
      FUNCT3_BGEU: return BR_GEU;
      default:     return BR_NONE;
    endcase
  endfunction

  // instruction fields
  assign opcode = stage.insn[6:0];
  assign rd     = stage.insn[11:7];
  assign funct3 = stage.insn[14:12];
  assign rs1    = stage.insn[19:15];
  assign rs2    = stage.insn[24:20];
  assign funct7 = stage.insn[31:25];
  assign alt    = (funct7 == FUNCT7_ALT);

  // sign extended immediates
  assign imm_i = {{20{stage.insn[31]}}, stage.insn[31:20]};
  assign imm_b = {{19{stage.insn[31]}}, stage.insn[31], stage.insn[7],
                  stage.insn[30:25], stage.insn[11:8], 1'b0};
  assign imm_u = {stage.insn[31:12], 12'b0};

  always_comb begin
    decoded.pc       = stage.pc;
    decoded.insn     = stage.insn;
    decoded.status   = stage.status;
    decoded.rd       = rd;
    decoded.rs1      = rs1;
    decoded.rs2      = rs2;
    decoded.rs1_data = rs1_data;
    decoded.rs2_data = rs2_data;
    decoded.rd_write = 1'b0;
    decoded.use_imm  = 1'b0;
    decoded.alu_op   = ALU_ADD;
    decoded.br_cond  = BR_NONE;
    decoded.imm      = '0;
    case (opcode)
      OPCODE_LUI: begin
        decoded.rd_write = 1'b1;
        decoded.use_imm  = 1'b1;
        decoded.alu_op   = ALU_PASS_IMM;
        decoded.imm      = imm_u;
      end
      OPCODE_OP_IMM: begin
        // addi has no sub form, only srai uses the alt bit
        decoded.rd_write = 1'b1;
        decoded.use_imm  = 1'b1;
        decoded.alu_op   = alu_from_funct3(funct3, 1'b0, alt);
        decoded.imm      = imm_i;
      end
      OPCODE_OP: begin
        decoded.rd_write = 1'b1;
        decoded.alu_op   = alu_from_funct3(funct3, alt, alt);
      end
      OPCODE_BRANCH: begin
        decoded.br_cond = branch_from_funct3(funct3);
        decoded.imm     = imm_b;
      end
      default: begin
        // anything else retires as a no-op
        decoded.rd_write = 1'b0;
      end
    endcase
    if (rd == '0) begin
      decoded.rd_write = 1'b0;
    end
  end

endmodule

// ==== hdl/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  rv_pkg::execute_stage_t stage,
  input  rv_pkg::result_stage_t  mem_stage,
  input  rv_pkg::result_stage_t  wb_stage,
  output rv_pkg::result_stage_t  result,
  output logic                   branch_taken,
  output rv_pkg::word_t          branch_target
);
  import rv_pkg::*;

  word_t      op_a;
  word_t      rs2_val;
  word_t      op_b;
  logic [4:0] shamt;
  logic       equal;
  logic       lt_signed;
  logic       lt_unsigned;
  word_t      alu_out;

  // MX first, then WX, else the value read in decode
  function automatic word_t bypass(reg_idx_t idx, word_t reg_val,
                                   result_stage_t mem_s, result_stage_t wb_s);
    if (idx == '0) begin
      return reg_val;
    end
    if (mem_s.rd_write && (mem_s.rd == idx)) begin
      return mem_s.result;
    end
    if (wb_s.rd_write && (wb_s.rd == idx)) begin
      return wb_s.result;
    end
    return reg_val;
  endfunction

  assign op_a    = bypass(stage.rs1, stage.rs1_data, mem_stage, wb_stage);
  assign rs2_val = bypass(stage.rs2, stage.rs2_data, mem_stage, wb_stage);
  assign op_b    = stage.use_imm ? stage.imm : rs2_val;

  // shift amount from the low five bits only
  assign shamt = op_b[4:0];

  // compares shared by slt and the branches
  assign equal       = (op_a == op_b);
  assign lt_signed   = ($signed(op_a) < $signed(op_b));
  assign lt_unsigned = (op_a < op_b);

  always_comb begin
    case (stage.alu_op)
      ALU_ADD:      alu_out = op_a + op_b;
      ALU_SUB:      alu_out = op_a - op_b;
      ALU_SLL:      alu_out = op_a << shamt;
      ALU_SLT:      alu_out = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:     alu_out = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:      alu_out = op_a ^ op_b;
      ALU_SRL:      alu_out = op_a >> shamt;
      ALU_SRA:      alu_out = word_t'($signed(op_a) >>> shamt);
      ALU_OR:       alu_out = op_a | op_b;
      ALU_AND:      alu_out = op_a & op_b;
      ALU_PASS_IMM: alu_out = stage.imm;
      default:      alu_out = '0;
    endcase
  end

  always_comb begin
    case (stage.br_cond)
      BR_EQ:   branch_taken = equal;
      BR_NE:   branch_taken = !equal;
      BR_LT:   branch_taken = lt_signed;
      BR_GE:   branch_taken = !lt_signed;
      BR_LTU:  branch_taken = lt_unsigned;
      BR_GEU:  branch_taken = !lt_unsigned;
      default: branch_taken = 1'b0;
    endcase
  end

  // imm holds the B-type offset for branches
  assign branch_target = stage.pc + stage.imm;

  always_comb begin
    result.pc       = stage.pc;
    result.insn     = stage.insn;
    result.status   = stage.status;
    result.rd       = stage.rd;
    result.rd_write = stage.rd_write;
    result.result   = alu_out;
  end

endmodule

// ==== hdl/rv_pipeline.sv ====
`timescale 1ns/1ps

module rv_pipeline (
  input  logic                  clk,
  input  logic                  rst,
  output rv_pkg::word_t         imem_pc,
  input  rv_pkg::insn_t         imem_insn,
  output logic                  wb_we,
  output rv_pkg::reg_idx_t      wb_rd,
  output rv_pkg::word_t         wb_data,
  output rv_pkg::word_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status
);
  import rv_pkg::*;

  word_t          fetch_pc;
  logic           branch_taken;
  word_t          branch_target;
  reg_idx_t       rs1_idx;
  reg_idx_t       rs2_idx;
  word_t          rs1_data;
  word_t          rs2_data;
  decode_stage_t  decode_d;
  decode_stage_t  decode_q;
  execute_stage_t decoded;
  execute_stage_t execute_d;
  execute_stage_t execute_q;
  execute_stage_t execute_reset;
  result_stage_t  exec_result;
  result_stage_t  result_reset;
  result_stage_t  mem_q;
  result_stage_t  wb_q;

  rv_fetch u_fetch (
    .clk           (clk),
    .rst           (rst),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .pc            (fetch_pc)
  );

  assign imem_pc = fetch_pc;

  // taken branch squashes the fetch slot
  always_comb begin
    decode_d.pc     = fetch_pc;
    decode_d.insn   = imem_insn;
    decode_d.status = CYCLE_NO_STALL;
    if (branch_taken) begin
      decode_d.pc     = '0;
      decode_d.insn   = NOP_INSN;
      decode_d.status = CYCLE_TAKEN_BRANCH;
    end
  end

  rv_decode u_decode (
    .stage    (decode_q),
    .rs1      (rs1_idx),
    .rs2      (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .decoded  (decoded)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1_idx),
    .rs2      (rs2_idx),
    .rd       (wb_q.rd),
    .we       (wb_q.rd_write),
    .rd_data  (wb_q.result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // and the decode slot becomes a bubble too
  always_comb begin
    execute_d = decoded;
    if (branch_taken) begin
      execute_d        = '0;
      execute_d.insn   = NOP_INSN;
      execute_d.status = CYCLE_TAKEN_BRANCH;
    end
  end

  rv_execute u_execute (
    .stage         (execute_q),
    .mem_stage     (mem_q),
    .wb_stage      (wb_q),
    .result        (exec_result),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  // empty stage contents after reset
  always_comb begin
    execute_reset        = '0;
    execute_reset.status = CYCLE_RESET;
    result_reset         = '0;
    result_reset.status  = CYCLE_RESET;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      decode_q  <= '{pc: '0, insn: NOP_INSN, status: CYCLE_RESET};
      execute_q <= execute_reset;
      mem_q     <= result_reset;
      wb_q      <= result_reset;
    end else begin
      decode_q  <= decode_d;
      execute_q <= execute_d;
      mem_q     <= exec_result;
      // no data memory, memory stage passes straight through
      wb_q      <= mem_q;
    end
  end

  assign wb_we        = wb_q.rd_write;
  assign wb_rd        = wb_q.rd;
  assign wb_data      = wb_q.result;
  assign trace_pc     = wb_q.pc;
  assign trace_insn   = wb_q.insn;
  assign trace_status = wb_q.status;

endmodule

// ==== tb/rv_pipeline_properties.sv ====
`timescale 1ns/1ps

module rv_pipeline_properties (
  input logic                  clk,
  input logic                  rst,
  input rv_pkg::word_t         imem_pc,
  input logic                  wb_we,
  input rv_pkg::reg_idx_t      wb_rd,
  input rv_pkg::cycle_status_e trace_status
);
  import rv_pkg::*;

  // number of failed assertions
  int failure_count = 0;

  // register writes only come from real retirements
  we_only_on_retire: assert property (
    @(posedge clk) disable iff (rst) wb_we |-> (trace_status == CYCLE_NO_STALL)
  ) else begin
    failure_count++;
    $error("wb_we high while trace_status is %s", trace_status.name());
  end

  // x0 is never written
  no_write_to_x0: assert property (
    @(posedge clk) disable iff (rst) wb_we |-> (wb_rd != '0)
  ) else begin
    failure_count++;
    $error("register write to x0");
  end

  pc_word_aligned: assert property (
    @(posedge clk) disable iff (rst) (imem_pc[1:0] == 2'b00)
  ) else begin
    failure_count++;
    $error("imem_pc %h is not word aligned", imem_pc);
  end

endmodule

bind rv_pipeline rv_pipeline_properties u_properties (.*);

// ==== tb/rv_pipeline_tb.sv ====
`timescale 1ns/1ps

module rv_pipeline_tb;
  import rv_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int MAX_RETIRE   = 35;
  localparam int NUM_TESTS    = 5;
  // each test: alignment, reset, four reset bubbles, then its retirements
  localparam int CYCLE_LIMIT  = NUM_TESTS * (1 + RESET_CYCLES + 4 + MAX_RETIRE);
  localparam int PROG_DEPTH   = 64;

  // one expected writeback cycle
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    logic          we;
    reg_idx_t      rd;
    word_t         data;
  } retire_t;

  logic          clk = 1'b0;
  logic          rst = 1'b1;
  word_t         imem_pc;
  insn_t         imem_insn;
  logic          wb_we;
  reg_idx_t      wb_rd;
  word_t         wb_data;
  word_t         trace_pc;
  insn_t         trace_insn;
  cycle_status_e trace_status;

  insn_t   prog [0:PROG_DEPTH-1];
  int      prog_len    = 0;
  retire_t expected [$];
  int      seed        = 16830;
  int      cycle_count = 0;
  int      error_count = 0;
  int      pass_count  = 0;
  int      fail_count  = 0;

  rv_pipeline UUT (
    .clk          (clk),
    .rst          (rst),
    .imem_pc      (imem_pc),
    .imem_insn    (imem_insn),
    .wb_we        (wb_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status)
  );

  always #20 clk = ~clk;

  // instruction memory, zero word past the program
  always_comb begin
    imem_insn = NOP_INSN;
    if ((imem_pc >> 2) < prog_len) begin
      imem_insn = prog[imem_pc >> 2];
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic insn_t op_imm_insn(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                        logic [11:0] imm);
    return {imm, rs1, f3, rd, OPCODE_OP_IMM};
  endfunction

  function automatic insn_t op_insn(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic insn_t lui_insn(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, OPCODE_LUI};
  endfunction

  function automatic insn_t branch_insn(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                        logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH};
  endfunction

  function automatic word_t random_word();
    return $random(seed);
  endfunction

  // RV32I integer results
  function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      FUNCT3_ADD:  return alt ? a - b : a + b;
      FUNCT3_SLL:  return a << b[4:0];
      FUNCT3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      FUNCT3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      FUNCT3_XOR:  return a ^ b;
      FUNCT3_SR:   return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      FUNCT3_OR:   return a | b;
      default:     return a & b;
    endcase
  endfunction

  function automatic logic branch_model(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      FUNCT3_BEQ:  return a == b;
      FUNCT3_BNE:  return a != b;
      FUNCT3_BLT:  return $signed(a) < $signed(b);
      FUNCT3_BGE:  return $signed(a) >= $signed(b);
      FUNCT3_BLTU: return a < b;
      FUNCT3_BGEU: return a >= b;
      default:     return 1'b0;
    endcase
  endfunction

  task automatic clear_program();
    prog_len = 0;
  endtask

  task automatic add_insn(insn_t insn);
    prog[prog_len] = insn;
    prog_len++;
  endtask

  // walk the program in order and list every writeback cycle
  task automatic build_expected();
    word_t      regs [0:31];
    word_t      pc;
    word_t      next_pc;
    insn_t      insn;
    logic [2:0] f3;
    logic       alt;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_b;
    logic       taken;
    retire_t    r;
    retire_t    bubble;
    expected.delete();
    foreach (regs[i]) regs[i] = '0;
    bubble        = '0;
    bubble.insn   = NOP_INSN;
    bubble.status = CYCLE_TAKEN_BRANCH;
    pc = RESET_PC;
    while (((pc >> 2) < prog_len) && (expected.size() < MAX_RETIRE)) begin
      insn    = prog[pc >> 2];
      f3      = insn[14:12];
      alt     = (insn[31:25] == FUNCT7_ALT);
      a       = regs[insn[19:15]];
      b       = regs[insn[24:20]];
      imm_i   = {{20{insn[31]}}, insn[31:20]};
      imm_b   = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      taken   = 1'b0;
      next_pc = pc + PC_STEP;
      r        = '0;
      r.pc     = pc;
      r.insn   = insn;
      r.status = CYCLE_NO_STALL;
      r.rd     = insn[11:7];
      case (insn[6:0])
        OPCODE_LUI: begin
          r.we   = 1'b1;
          r.data = {insn[31:12], 12'b0};
        end
        OPCODE_OP_IMM: begin
          // only srai takes the alternate funct7
          r.we   = 1'b1;
          r.data = alu_model(f3, alt && (f3 == FUNCT3_SR), a, imm_i);
        end
        OPCODE_OP: begin
          r.we   = 1'b1;
          r.data = alu_model(f3, alt, a, b);
        end
        OPCODE_BRANCH: begin
          taken = branch_model(f3, a, b);
        end
        default: begin
          r.we = 1'b0;
        end
      endcase
      if (r.rd == '0) begin
        r.we = 1'b0;
      end
      if (r.we) begin
        regs[r.rd] = r.data;
      end
      expected.push_back(r);
      if (taken) begin
        next_pc = pc + imm_b;
        expected.push_back(bubble);
        expected.push_back(bubble);
      end
      pc = next_pc;
    end
  endtask

  task automatic compare_word(string test, string field, word_t exp, word_t act);
    if (act !== exp) begin
      $display("error: %s %s expected %h actual %h", test, field, exp, act);
      error_count++;
    end
  endtask

  task automatic compare_reg(string test, reg_idx_t exp, reg_idx_t act);
    if (act !== exp) begin
      $display("error: %s wb_rd expected x%0d actual x%0d", test, exp, act);
      error_count++;
    end
  endtask

  task automatic compare_status(string test, cycle_status_e exp, cycle_status_e act);
    if (act !== exp) begin
      $display("error: %s trace_status expected %s actual %s", test, exp.name(), act.name());
      error_count++;
    end
  endtask

  task automatic compare_flag(string test, logic exp, logic act);
    if (act !== exp) begin
      $display("error: %s wb_we expected %b actual %b", test, exp, act);
      error_count++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  endtask

  // reset, then follow writeback one cycle at a time
  task automatic run_and_check(string name);
    retire_t exp;
    int      errors_before;
    errors_before = error_count;
    build_expected();
    apply_reset();
    repeat (4) begin
      @(negedge clk);
      compare_status(name, CYCLE_RESET, trace_status);
      compare_flag(name, 1'b0, wb_we);
    end
    foreach (expected[i]) begin
      @(negedge clk);
      exp = expected[i];
      compare_status(name, exp.status, trace_status);
      compare_word(name, "trace_pc", exp.pc, trace_pc);
      compare_word(name, "trace_insn", exp.insn, trace_insn);
      compare_flag(name, exp.we, wb_we);
      if (exp.we) begin
        compare_reg(name, exp.rd, wb_rd);
        compare_word(name, "wb_data", exp.data, wb_data);
      end
    end
    if (error_count == errors_before) begin
      pass_count++;
      $display("test %s: passed, %0d retirements", name, expected.size());
    end else begin
      fail_count++;
      $display("test %s: failed, %0d mismatches", name, error_count - errors_before);
    end
  endtask

  task automatic test_reset_sequence();
    clear_program();
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd1, 5'd0, 12'h123));
    add_insn(lui_insn(5'd2, 20'habcde));
    run_and_check("reset_sequence");
  endtask

  task automatic test_alu_coverage();
    word_t r [0:15];
    foreach (r[i]) r[i] = random_word();
    clear_program();
    add_insn(lui_insn(5'd1, r[0][19:0]));
    add_insn(lui_insn(5'd2, r[1][19:0]));
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd3, 5'd0, r[2][11:0]));
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd4, 5'd0, r[3][11:0]));
    add_insn(op_imm_insn(FUNCT3_SLT, 5'd5, 5'd1, r[4][11:0]));
    add_insn(op_imm_insn(FUNCT3_SLTU, 5'd6, 5'd2, r[5][11:0]));
    add_insn(op_imm_insn(FUNCT3_XOR, 5'd7, 5'd3, r[6][11:0]));
    add_insn(op_imm_insn(FUNCT3_OR, 5'd8, 5'd4, r[7][11:0]));
    add_insn(op_imm_insn(FUNCT3_AND, 5'd9, 5'd1, r[8][11:0]));
    add_insn(op_imm_insn(FUNCT3_SLL, 5'd10, 5'd2, {7'b0, r[9][4:0]}));
    add_insn(op_imm_insn(FUNCT3_SR, 5'd11, 5'd1, {7'b0, r[10][4:0]}));
    add_insn(op_imm_insn(FUNCT3_SR, 5'd12, 5'd1, {FUNCT7_ALT, r[11][4:0]}));
    add_insn(op_insn(7'b0, FUNCT3_ADD, 5'd13, 5'd1, 5'd2));
    add_insn(op_insn(FUNCT7_ALT, FUNCT3_ADD, 5'd14, 5'd3, 5'd4));
    add_insn(op_insn(7'b0, FUNCT3_SLL, 5'd15, 5'd1, 5'd3));
    add_insn(op_insn(7'b0, FUNCT3_SLT, 5'd16, 5'd1, 5'd2));
    add_insn(op_insn(7'b0, FUNCT3_SLTU, 5'd17, 5'd3, 5'd4));
    add_insn(op_insn(7'b0, FUNCT3_XOR, 5'd18, 5'd1, 5'd4));
    add_insn(op_insn(7'b0, FUNCT3_SR, 5'd19, 5'd2, 5'd3));
    add_insn(op_insn(FUNCT7_ALT, FUNCT3_SR, 5'd20, 5'd1, 5'd4));
    add_insn(op_insn(7'b0, FUNCT3_OR, 5'd21, 5'd2, 5'd3));
    add_insn(op_insn(7'b0, FUNCT3_AND, 5'd22, 5'd1, 5'd4));
    run_and_check("alu_coverage");
  endtask

  task automatic test_dependent_chains();
    word_t r [0:2];
    foreach (r[i]) r[i] = random_word();
    clear_program();
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd1, 5'd0, r[0][11:0]));
    // both sources from the previous instruction
    add_insn(op_insn(7'b0, FUNCT3_ADD, 5'd2, 5'd1, 5'd1));
    add_insn(op_insn(FUNCT7_ALT, FUNCT3_ADD, 5'd3, 5'd2, 5'd1));
    add_insn(op_insn(7'b0, FUNCT3_SLL, 5'd4, 5'd1, 5'd3));
    add_insn(op_insn(7'b0, FUNCT3_OR, 5'd5, 5'd3, 5'd3));
    add_insn(op_insn(7'b0, FUNCT3_AND, 5'd6, 5'd3, 5'd4));
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd6, 5'd6, r[1][11:0]));
    add_insn(op_insn(7'b0, FUNCT3_SLT, 5'd7, 5'd6, 5'd5));
    add_insn(op_insn(FUNCT7_ALT, FUNCT3_SR, 5'd8, 5'd6, 5'd7));
    add_insn(op_insn(7'b0, FUNCT3_SLTU, 5'd9, 5'd8, 5'd6));
    // memory stage value must win over writeback
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd10, 5'd0, r[2][11:0]));
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd10, 5'd0, 12'd2));
    add_insn(op_insn(7'b0, FUNCT3_ADD, 5'd11, 5'd10, 5'd0));
    run_and_check("dependent_chains");
  endtask

  task automatic test_branches();
    logic [2:0] conds [0:5];
    reg_idx_t   pairs [0:5][0:3];
    // taken rs1, taken rs2, not-taken rs1, not-taken rs2 with x1 = -1, x2 = x3 = 1
    conds = '{FUNCT3_BEQ, FUNCT3_BNE, FUNCT3_BLT, FUNCT3_BGE, FUNCT3_BLTU, FUNCT3_BGEU};
    pairs = '{'{2, 3, 1, 2}, '{1, 2, 2, 3}, '{1, 2, 2, 1},
              '{2, 1, 1, 2}, '{2, 1, 1, 2}, '{1, 2, 2, 1}};
    clear_program();
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd1, 5'd0, 12'hfff));
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd2, 5'd0, 12'd1));
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd3, 5'd0, 12'd1));
    for (int i = 0; i < 6; i++) begin
      add_insn(branch_insn(conds[i], pairs[i][0], pairs[i][1], 13'd8));
      add_insn(op_imm_insn(FUNCT3_ADD, 5'd10, 5'd10, 12'd1));
      add_insn(branch_insn(conds[i], pairs[i][2], pairs[i][3], 13'd8));
      add_insn(op_imm_insn(FUNCT3_ADD, 5'd11, 5'd11, 12'd1));
    end
    run_and_check("branches");
  endtask

  task automatic test_x0_writes();
    word_t r [0:2];
    foreach (r[i]) r[i] = random_word();
    clear_program();
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd0, 5'd0, r[0][11:0] | 12'h001));
    add_insn(lui_insn(5'd0, r[1][19:0] | 20'h00001));
    add_insn(op_insn(7'b0, FUNCT3_ADD, 5'd1, 5'd0, 5'd0));
    add_insn(op_imm_insn(FUNCT3_ADD, 5'd2, 5'd0, r[2][11:0]));
    add_insn(op_insn(7'b0, FUNCT3_OR, 5'd0, 5'd2, 5'd2));
    add_insn(op_insn(FUNCT7_ALT, FUNCT3_ADD, 5'd3, 5'd0, 5'd2));
    add_insn(op_imm_insn(FUNCT3_OR, 5'd4, 5'd0, 12'h7f0));
    run_and_check("x0_writes");
  endtask

  initial begin
    test_reset_sequence();
    test_alu_coverage();
    test_dependent_chains();
    test_branches();
    test_x0_writes();
    $display("summary: %0d passed, %0d failed, %0d mismatches, %0d assertion failures",
             pass_count, fail_count, error_count, UUT.u_properties.failure_count);
    if ((fail_count == 0) && (UUT.u_properties.failure_count == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== rv_pipe.f ====
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_pipeline.sv
tb/rv_pipeline_properties.sv
tb/rv_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: rv_pipe

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/rv_regfile.sv
      - hdl/rv_fetch.sv
      - hdl/rv_decode.sv
      - hdl/rv_execute.sv
      - hdl/rv_pipeline.sv
  - target: simulation
    files:
      - tb/rv_pipeline_properties.sv
      - tb/rv_pipeline_tb.sv
